// File: hw/rename_pkg.sv
// rename core package with sizes, the ALU opcode enum and the stage records
`default_nettype none

package rename_pkg;

    //////////////////////////////////////////////////////////////////////
    // sizes
    //////////////////////////////////////////////////////////////////////
    localparam int xlen     = 32;                 // datapath width
    localparam int num_ar   = 8;                  // architectural registers
    localparam int num_pr   = 16;                 // physical registers
    localparam int num_free = num_pr - num_ar;    // free list slots
    localparam int imm_w    = 16;                 // immediate field
    localparam int ar_w     = $clog2(num_ar);
    localparam int pr_w     = $clog2(num_pr);
    localparam int fl_w     = $clog2(num_free) + 1;  // extra msb is the wrap bit

    typedef logic [ar_w-1:0] ar_idx_t;
    typedef logic [pr_w-1:0] pr_idx_t;
    typedef logic [fl_w-1:0] fl_ptr_t;

    // integer ops only, no memory or branch
    typedef enum logic [3:0] {
        op_add  = 4'd0,
        op_sub  = 4'd1,
        op_and  = 4'd2,
        op_or   = 4'd3,
        op_xor  = 4'd4,
        op_sll  = 4'd5,
        op_srl  = 4'd6,
        op_addi = 4'd7,   // rs1 + sign extended imm
        op_lui  = 4'd8    // imm into upper half
    } alu_op_e;

    //////////////////////////////////////////////////////////////////////
    // stage records
    //////////////////////////////////////////////////////////////////////
    typedef struct packed {
        alu_op_e          op;
        ar_idx_t          rd;
        ar_idx_t          rs1;
        ar_idx_t          rs2;
        logic [imm_w-1:0] imm;
    } inst_t;

    // decode to execute
    typedef struct packed {
        logic             valid;
        alu_op_e          op;
        ar_idx_t          rd;
        pr_idx_t          pr_dst;   // newly allocated, 0 when rd is 0
        pr_idx_t          pr_old;   // previous mapping of rd
        pr_idx_t          pr_src1;
        pr_idx_t          pr_src2;
        logic [imm_w-1:0] imm;
    } renamed_t;

    // execute to result
    typedef struct packed {
        logic            valid;
        ar_idx_t         rd;
        pr_idx_t         pr_dst;
        pr_idx_t         pr_old;
        logic [xlen-1:0] value;
    } exec_result_t;

    typedef struct packed {
        logic            valid;
        ar_idx_t         rd;
        pr_idx_t         pr_dst;
        logic [xlen-1:0] value;
    } commit_t;

    // regfile write port, doubles as the forwarding bus
    typedef struct packed {
        logic            en;
        pr_idx_t         idx;
        logic [xlen-1:0] data;
    } pr_write_t;

    typedef struct packed {
        logic    en;
        pr_idx_t idx;
    } pr_release_t;

endpackage

`default_nettype wire

// File: hw/free_list.sv
// free list of physical registers as a circular buffer with wrap bit pointers
`timescale 1ns/100ps
`default_nettype none

module free_list
    import rename_pkg::*;
(
    input  logic        clock,
    input  logic        reset,
    input  logic        alloc,        // pop head
    input  pr_release_t release_in,   // push at tail
    output pr_idx_t     free_pr
);

    pr_idx_t slots [num_free];
    fl_ptr_t head;
    fl_ptr_t tail;
    logic    empty;
    logic    full;

    // same slot index, wrap bits tell empty from full
    assign empty = (head == tail);
    assign full  = (head[fl_w-2:0] == tail[fl_w-2:0]) && (head[fl_w-1] != tail[fl_w-1]);

    assign free_pr = slots[head[fl_w-2:0]];

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < num_free; i++) begin
                slots[i] <= pr_idx_t'(num_ar + i);   // p8..p15 start free
            end
            head <= '0;
            tail <= fl_ptr_t'(num_free);   // starts full
        end else begin
            if (alloc) begin
                head <= head + 1'b1;
            end
            if (release_in.en) begin
                slots[tail[fl_w-2:0]] <= release_in.idx;
                tail <= tail + 1'b1;
            end
        end
    end

    // at most three in flight, so neither edge of the count is ever hit
    a_no_underflow: assert property (@(posedge clock) disable iff (reset)
        alloc |-> !empty)
        else $error("allocate from an empty free list");

    a_no_overflow: assert property (@(posedge clock) disable iff (reset)
        release_in.en |-> !full)
        else $error("release into a full free list");

endmodule

`default_nettype wire

// File: hw/rename_decode.sv
// decode and rename stage with the speculative map table and the decode register
`timescale 1ns/100ps
`default_nettype none

module rename_decode
    import rename_pkg::*;
(
    input  logic        clock,
    input  logic        reset,
    input  logic        inst_valid,
    input  inst_t       inst,
    input  pr_release_t pr_release,   // from writeback
    output renamed_t    renamed
);

    pr_idx_t  map_table [num_ar];   // arch -> phys, speculative only
    pr_idx_t  free_pr;              // head of the free list
    logic     alloc;
    renamed_t renamed_next;

    //////////////////////////////////////////////////////////////////////
    // free list
    //////////////////////////////////////////////////////////////////////

    // r0 is hardwired, never gets a new register
    assign alloc = inst_valid && (inst.rd != '0);

    free_list u_free_list (
        .clock   (clock),
        .reset   (reset),
        .alloc   (alloc),
        .release_in (pr_release),
        .free_pr (free_pr)
    );

    //////////////////////////////////////////////////////////////////////
    // lookup
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        renamed_next.valid   = inst_valid;
        renamed_next.op      = inst.op;
        renamed_next.rd      = inst.rd;
        renamed_next.pr_dst  = alloc ? free_pr : '0;   // r0 stays on p0
        renamed_next.pr_old  = map_table[inst.rd];     // p0 for r0
        renamed_next.pr_src1 = map_table[inst.rs1];
        renamed_next.pr_src2 = map_table[inst.rs2];
        renamed_next.imm     = inst.imm;
    end

    // map update lands on the same edge as the decode register,
    // so the very next instruction already sees the new name
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < num_ar; i++) begin
                map_table[i] <= pr_idx_t'(i);   // identity map out of reset
            end
        end else if (alloc) begin
            map_table[inst.rd] <= free_pr;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // decode register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            renamed.valid <= 1'b0;
        end else begin
            renamed <= renamed_next;
        end
    end

    // r0 keeps p0 for the whole run
    a_r0_pinned: assert property (@(posedge clock) disable iff (reset)
        map_table[0] == '0)
        else $error("arch r0 mapped away from p0");

    // p0 must never show up in the free list
    a_no_p0_alloc: assert property (@(posedge clock) disable iff (reset)
        alloc |-> (free_pr != '0))
        else $error("p0 handed out by the free list");

endmodule

`default_nettype wire

// File: hw/alu_execute.sv
// execute stage with operand read, bypass, integer ALU and execute register
`timescale 1ns/100ps
`default_nettype none

module alu_execute
    import rename_pkg::*;
(
    input  logic            clock,
    input  logic            reset,
    input  renamed_t        renamed,
    input  logic [xlen-1:0] rd_data1,
    input  logic [xlen-1:0] rd_data2,
    input  pr_write_t       fwd,       // writeback bus, two ahead
    output pr_idx_t         rd_idx1,
    output pr_idx_t         rd_idx2,
    output exec_result_t    result
);

    logic [xlen-1:0] op_a;
    logic [xlen-1:0] op_b;
    logic [xlen-1:0] imm_sext;
    logic [xlen-1:0] alu_out;
    exec_result_t    result_next;

    // youngest producer wins, p0 always reads zero
    function automatic logic [xlen-1:0] pick_operand(
        input pr_idx_t         src,
        input logic [xlen-1:0] rf_data,
        input exec_result_t    own,
        input pr_write_t       wb
    );
        if (src == '0) return '0;
        if (own.valid && (own.pr_dst == src)) return own.value;   // one ahead
        if (wb.en && (wb.idx == src)) return wb.data;             // two ahead
        return rf_data;
    endfunction

    assign rd_idx1 = renamed.pr_src1;
    assign rd_idx2 = renamed.pr_src2;

    assign op_a     = pick_operand(renamed.pr_src1, rd_data1, result, fwd);
    assign op_b     = pick_operand(renamed.pr_src2, rd_data2, result, fwd);
    assign imm_sext = {{(xlen-imm_w){renamed.imm[imm_w-1]}}, renamed.imm};

    //////////////////////////////////////////////////////////////////////
    // ALU
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        case (renamed.op)
            op_add:  alu_out = op_a + op_b;
            op_sub:  alu_out = op_a - op_b;
            op_and:  alu_out = op_a & op_b;
            op_or:   alu_out = op_a | op_b;
            op_xor:  alu_out = op_a ^ op_b;
            op_sll:  alu_out = op_a << op_b[4:0];   // low 5 bits only
            op_srl:  alu_out = op_a >> op_b[4:0];   // logical
            op_addi: alu_out = op_a + imm_sext;
            op_lui:  alu_out = {renamed.imm, {(xlen-imm_w){1'b0}}};
            default: alu_out = '0;
        endcase
    end

    always_comb begin
        result_next.valid  = renamed.valid;
        result_next.rd     = renamed.rd;
        result_next.pr_dst = renamed.pr_dst;
        result_next.pr_old = renamed.pr_old;
        result_next.value  = alu_out;
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            result.valid <= 1'b0;
        end else begin
            result <= result_next;
        end
    end

    a_legal_op: assert property (@(posedge clock) disable iff (reset)
        renamed.valid |-> renamed.op inside {op_add, op_sub, op_and, op_or, op_xor,
                                             op_sll, op_srl, op_addi, op_lui})
        else $error("illegal opcode %0d reached execute", renamed.op);

endmodule

`default_nettype wire

// File: hw/result_writeback.sv
// result stage, drives the regfile write, the old register release and commit
`timescale 1ns/100ps
`default_nettype none

module result_writeback
    import rename_pkg::*;
(
    input  logic         clock,
    input  logic         reset,
    input  exec_result_t result,
    output pr_write_t    pr_write,
    output pr_release_t  pr_release,
    output commit_t      commit
);

    exec_result_t result_q;
    logic         writes_rd;   // r0 results go nowhere

    always_ff @(posedge clock) begin
        if (reset) begin
            result_q.valid <= 1'b0;
        end else begin
            result_q <= result;
        end
    end

    assign writes_rd = result_q.valid && (result_q.rd != '0);

    // in order completion, so the displaced register is dead here
    always_comb begin
        pr_write.en    = writes_rd;
        pr_write.idx   = result_q.pr_dst;
        pr_write.data  = result_q.value;
        pr_release.en  = writes_rd;
        pr_release.idx = result_q.pr_old;
    end

    always_comb begin
        commit.valid  = result_q.valid;
        commit.rd     = result_q.rd;
        commit.pr_dst = result_q.pr_dst;
        commit.value  = result_q.value;
    end

    // decode must have handed out a fresh register, never the old one
    a_new_not_old: assert property (@(posedge clock) disable iff (reset)
        (pr_write.en && pr_release.en) |-> (pr_write.idx != pr_release.idx))
        else $error("p%0d written and released together", pr_write.idx);

endmodule

`default_nettype wire

// File: hw/phys_regfile.sv
// physical register file, 16 x 32 with two async reads and one clocked write
`timescale 1ns/100ps
`default_nettype none

module phys_regfile
    import rename_pkg::*;
(
    input  logic            clock,
    input  logic            reset,
    input  pr_idx_t         rd_idx1,
    input  pr_idx_t         rd_idx2,
    input  pr_write_t       pr_write,
    output logic [xlen-1:0] rd_data1,
    output logic [xlen-1:0] rd_data2
);

    logic [xlen-1:0] regs [num_pr];

    // p0 is the zero register, never written
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < num_pr; i++) begin
                regs[i] <= '0;
            end
        end else if (pr_write.en && (pr_write.idx != '0)) begin
            regs[pr_write.idx] <= pr_write.data;
        end
    end

    // no internal bypass, execute handles same cycle writes
    assign rd_data1 = regs[rd_idx1];
    assign rd_data2 = regs[rd_idx2];

endmodule

`default_nettype wire

// File: hw/rename_core.sv
// rename core top level, single issue rename, execute and writeback pipeline
`timescale 1ns/100ps
`default_nettype none

module rename_core
    import rename_pkg::*;
(
    input  logic    clock,
    input  logic    reset,
    input  logic    inst_valid,   // one instruction per strobe
    input  inst_t   inst,
    output commit_t commit        // one record per instruction, 3 cycles later
);

    renamed_t        renamed;        // decode -> execute
    exec_result_t    result;         // execute -> result
    pr_write_t       pr_write;       // result -> regfile, execute bypass
    pr_release_t     pr_release;     // result -> free list
    pr_idx_t         rd_idx1;
    pr_idx_t         rd_idx2;
    logic [xlen-1:0] rd_data1;
    logic [xlen-1:0] rd_data2;

    rename_decode u_decode (
        .clock      (clock),
        .reset      (reset),
        .inst_valid (inst_valid),
        .inst       (inst),
        .pr_release (pr_release),   // freed registers back into the list
        .renamed    (renamed)
    );

    alu_execute u_execute (
        .clock    (clock),
        .reset    (reset),
        .renamed  (renamed),
        .rd_data1 (rd_data1),
        .rd_data2 (rd_data2),
        .fwd      (pr_write),
        .rd_idx1  (rd_idx1),
        .rd_idx2  (rd_idx2),
        .result   (result)
    );

    result_writeback u_result (
        .clock      (clock),
        .reset      (reset),
        .result     (result),
        .pr_write   (pr_write),
        .pr_release (pr_release),
        .commit     (commit)
    );

    phys_regfile u_regfile (
        .clock    (clock),
        .reset    (reset),
        .rd_idx1  (rd_idx1),
        .rd_idx2  (rd_idx2),
        .pr_write (pr_write),
        .rd_data1 (rd_data1),
        .rd_data2 (rd_data2)
    );

endmodule

`default_nettype wire

// File: verif/rename_core_tb.sv
// testbench for the rename core, random and directed stimulus against a reference model
`timescale 1ns/100ps
`default_nettype none

module rename_core_tb
    import rename_pkg::*;
;

    // one outstanding instruction as the model sees it
    typedef struct packed {
        ar_idx_t         rd;
        logic [xlen-1:0] value;
        logic [31:0]     due;     // edge on which commit is consumed
    } expected_t;

    logic        clock;
    logic        reset;
    logic        inst_valid;
    inst_t       inst;
    commit_t     commit;

    logic [xlen-1:0] arch_regs [num_ar];   // architectural state of the model
    expected_t       expected [$];         // in order, oldest first
    int unsigned     edge_count = 0;
    logic [31:0]     rng_state  = 32'd42394;

    rename_core DUT (
        .clock      (clock),
        .reset      (reset),
        .inst_valid (inst_valid),
        .inst       (inst),
        .commit     (commit)
    );

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;   // 40 ns period
    end

    always @(posedge clock) edge_count <= edge_count + 1;

    //////////////////////////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////////////////////////

    task automatic abort_run(input string line);
        $display("%s", line);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped");
    endtask

    // xorshift32
    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // architectural semantics where r0 reads zero and never changes
    function automatic void predict(input inst_t word, input int unsigned accept_edge);
        logic [xlen-1:0] a;
        logic [xlen-1:0] b;
        logic [xlen-1:0] imm_ext;
        logic [xlen-1:0] value;
        expected_t       entry;
        a       = (word.rs1 == 3'd0) ? '0 : arch_regs[word.rs1];
        b       = (word.rs2 == 3'd0) ? '0 : arch_regs[word.rs2];
        imm_ext = {{16{word.imm[15]}}, word.imm};
        case (word.op)
            op_add:  value = a + b;
            op_sub:  value = a - b;
            op_and:  value = a & b;
            op_or:   value = a | b;
            op_xor:  value = a ^ b;
            op_sll:  value = a << b[4:0];
            op_srl:  value = a >> b[4:0];
            op_addi: value = a + imm_ext;
            op_lui:  value = {word.imm, 16'h0000};
            default: value = '0;
        endcase
        if (word.rd != 3'd0) begin
            arch_regs[word.rd] = value;
        end
        entry.rd    = word.rd;
        entry.value = value;    // commit carries the result even for r0
        entry.due   = accept_edge + 3;
        expected.push_back(entry);
    endfunction

    task automatic send(input alu_op_e op, input ar_idx_t rd, input ar_idx_t rs1,
                        input ar_idx_t rs2, input logic [15:0] imm);
        inst_t word;
        word.op  = op;
        word.rd  = rd;
        word.rs1 = rs1;
        word.rs2 = rs2;
        word.imm = imm;
        @(posedge clock);
        inst_valid <= 1'b1;
        inst       <= word;
        // counter still shows the previous edge and the DUT takes this word one edge later
        predict(word, edge_count + 2);
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) begin
            @(posedge clock);
            inst_valid <= 1'b0;
            inst       <= '0;
        end
    endtask

    task automatic wait_for_drain(input int limit);
        int waited;
        waited = 0;
        while (expected.size() != 0) begin
            if (waited >= limit) begin
                abort_run($sformatf("timeout: %0d commits still missing after %0d cycles",
                                    expected.size(), limit));
            end
            @(posedge clock);
            inst_valid <= 1'b0;
            waited++;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // commit checker sampling mid cycle
    //////////////////////////////////////////////////////////////////////

    always @(negedge clock) begin : check_commit
        expected_t head;
        assert (commit.valid === 1'b0 || commit.valid === 1'b1)
            else abort_run($sformatf("error at %0t: commit.valid is unknown", $time));
        if (commit.valid) begin
            assert (expected.size() != 0)
                else abort_run($sformatf("error at %0t: commit with nothing in flight", $time));
            head = expected.pop_front();
            assert (head.due == edge_count + 1)   // consumed at the next edge
                else abort_run($sformatf("error at %0t: commit due at edge %0d seen at %0d",
                                         $time, head.due, edge_count + 1));
            assert (commit.rd == head.rd)
                else abort_run($sformatf("error at %0t: rd %0d, expected %0d",
                                         $time, commit.rd, head.rd));
            assert (commit.value === head.value)
                else abort_run($sformatf("error at %0t: r%0d value %h, expected %h",
                                         $time, head.rd, commit.value, head.value));
            assert ((commit.pr_dst == '0) == (head.rd == 3'd0))   // only r0 sits on p0
                else abort_run($sformatf("error at %0t: r%0d committed on p%0d",
                                         $time, commit.rd, commit.pr_dst));
        end else begin
            assert (expected.size() == 0 || expected[0].due != edge_count + 1)
                else abort_run($sformatf("error at %0t: commit for r%0d did not arrive",
                                         $time, expected[0].rd));
        end
    end

    //////////////////////////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////////////////////////

    initial begin : stimulus
        ar_idx_t     prev;
        ar_idx_t     rd;
        logic [31:0] r;
        for (int i = 0; i < num_ar; i++) begin
            arch_regs[i] = '0;
        end
        reset      = 1'b1;
        inst_valid = 1'b0;
        inst       = '0;
        repeat (10) @(posedge clock);
        reset <= 1'b0;
        idle(6);   // checker flags any stray commit here

        // operands first, then every op once
        send(op_lui,  3'd1, 3'd0, 3'd0, 16'h1234);
        send(op_addi, 3'd1, 3'd1, 3'd0, 16'h5678);
        send(op_lui,  3'd2, 3'd0, 3'd0, 16'hf0f0);
        send(op_addi, 3'd2, 3'd2, 3'd0, 16'hfffd);   // negative imm
        send(op_addi, 3'd3, 3'd0, 3'd0, 16'h0007);
        send(op_addi, 3'd7, 3'd0, 3'd0, 16'h0025);   // shift of 37 uses 5
        send(op_add,  3'd4, 3'd1, 3'd2, 16'h0000);
        send(op_sub,  3'd5, 3'd1, 3'd2, 16'h0000);
        send(op_and,  3'd6, 3'd1, 3'd2, 16'h0000);
        send(op_or,   3'd4, 3'd1, 3'd2, 16'h0000);
        send(op_xor,  3'd5, 3'd1, 3'd2, 16'h0000);
        send(op_sll,  3'd6, 3'd1, 3'd3, 16'h0000);
        send(op_srl,  3'd4, 3'd2, 3'd3, 16'h0000);
        send(op_sll,  3'd5, 3'd2, 3'd7, 16'h0000);
        send(op_srl,  3'd6, 3'd1, 3'd7, 16'h0000);
        wait_for_drain(20);

        // dependent chain where each op reads the one just before
        prev = 3'd1;
        for (int i = 0; i < 16; i++) begin
            rd = ar_idx_t'(1 + (i * 3) % 7);
            send((i % 2) ? op_add : op_addi, rd, prev, prev, 16'(i + 1));
            prev = rd;
        end
        for (int i = 0; i < 6; i++) begin
            send(op_addi, 3'd5, 3'd5, 3'd0, 16'h0001);   // same register over and over
        end
        wait_for_drain(20);

        // long run of writes wraps the free list many times
        for (int i = 0; i < 48; i++) begin
            send((i % 3 == 0) ? op_add : op_addi, ar_idx_t'(1 + i % 7),
                 ar_idx_t'((i + 3) % 8), ar_idx_t'((i + 5) % 8), 16'(i * 37 + 1));
        end
        wait_for_drain(20);

        // r0 as target, then r0 as source
        send(op_addi, 3'd0, 3'd1, 3'd0, 16'h0055);
        send(op_add,  3'd0, 3'd1, 3'd2, 16'h0000);
        send(op_or,   3'd4, 3'd0, 3'd1, 16'h0000);
        send(op_add,  3'd5, 3'd0, 3'd0, 16'h0000);
        send(op_sub,  3'd6, 3'd0, 3'd2, 16'h0000);
        wait_for_drain(20);

        // random stream with gaps
        for (int i = 0; i < 200; i++) begin
            r = next_random();
            send(alu_op_e'(r % 9), r[6:4], r[9:7], r[12:10], r[31:16]);
            if (r[13] && r[14]) begin
                idle(1 + int'(r[15]));
            end
        end
        wait_for_drain(20);
        idle(8);   // nothing else may commit

        $display("TEST PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: rename_core.f
hw/rename_pkg.sv
hw/free_list.sv
hw/rename_decode.sv
hw/alu_execute.sv
hw/result_writeback.sv
hw/phys_regfile.sv
hw/rename_core.sv
verif/rename_core_tb.sv

// File: Makefile
# Verilator build and run for the rename core testbench

VERILATOR ?= verilator
TOP       ?= rename_core_tb
FILELIST  ?= rename_core.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	-./$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "TEST PASSED" $(LOG); then echo "simulation ended early, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
